/* logic/motor_cfg.svh */
`ifndef MOTOR_CFG_SVH
`define MOTOR_CFG_SVH

// datapath widths
`define MOTOR_SPEED_W 16
`define MOTOR_STEP_W 16
`define MOTOR_ADDR_W 9

// speed table entries
`define MOTOR_TBL_DEPTH (1 << `MOTOR_ADDR_W)

`define MOTOR_AXES 2

// settling cycles after a direction change
`define MOTOR_REVERSE_DELAY 4

// smallest half period, keeps a step fetch inside one phase
`define MOTOR_MIN_HALF 8

`endif

/* logic/motor_pkg.sv */
`include "motor_cfg.svh"

package motor_pkg;

	typedef enum logic [1:0] {
		AXIS_IDLE    = 2'd0,
		AXIS_PREPARE = 2'd1,
		AXIS_RUNNING = 2'd2
	} axis_state_e;

	// CMD register view
	typedef struct packed {
		logic [`MOTOR_STEP_W-1:0]    steps;
		logic [32-3-`MOTOR_STEP_W-1:0] spare;
		logic                        dir;
		logic                        stop;
		logic                        start;
	} apb_cmd_t;

	// TBL register view
	typedef struct packed {
		logic [`MOTOR_SPEED_W-1:0]                 speed;
		logic [32-`MOTOR_ADDR_W-`MOTOR_SPEED_W-1:0] spare;
		logic [`MOTOR_ADDR_W-1:0]                  addr;
	} apb_tbl_t;

	typedef union packed {
		apb_cmd_t cmd;
		apb_tbl_t tbl;
	} apb_wword_u;

endpackage

/* logic/apb_regs.sv */
`timescale 1ns/1ns
`include "motor_cfg.svh"

module apb_regs (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic                            i_psel,
	input  logic                            i_penable,
	input  logic                            i_pwrite,
	input  logic [7:0]                      i_paddr,
	input  logic [31:0]                     i_pwdata,
	input  motor_pkg::axis_state_e          i_state [`MOTOR_AXES],
	input  logic [`MOTOR_AXES-1:0]          i_dir,
	input  logic signed [`MOTOR_STEP_W-1:0] i_position [`MOTOR_AXES],
	output logic [31:0]                     o_prdata,
	output logic [`MOTOR_AXES-1:0]          o_start,
	output logic [`MOTOR_AXES-1:0]          o_stop,
	output logic [`MOTOR_AXES-1:0]          o_cmd_dir,
	output logic [`MOTOR_STEP_W-1:0]        o_cmd_steps [`MOTOR_AXES],
	output logic [`MOTOR_SPEED_W-1:0]       o_speed_max [`MOTOR_AXES],
	output logic [`MOTOR_ADDR_W-1:0]        o_ramp_len,
	output logic                            o_tbl_we,
	output logic [`MOTOR_ADDR_W-1:0]        o_tbl_addr,
	output logic [`MOTOR_SPEED_W-1:0]       o_tbl_data
);
	localparam logic [7:0] TBL_ADDR  = 8'h40;
	localparam logic [7:0] RAMP_ADDR = 8'h44;

	motor_pkg::apb_wword_u wword;
	logic                  wr_en;
	logic [3:0]            blk;
	logic [1:0]            reg_sel;

	assign wword   = i_pwdata;
	assign wr_en   = i_psel & i_penable & i_pwrite;
	// axis block index and register within the block
	assign blk     = i_paddr[7:4];
	assign reg_sel = i_paddr[3:2];

	// command strobes and config registers
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_start    <= '0;
			o_stop     <= '0;
			o_ramp_len <= '0;
			for (int n = 0; n < `MOTOR_AXES; n++) begin
				o_speed_max[n] <= '0;
			end
		end else begin
			for (int n = 0; n < `MOTOR_AXES; n++) begin
				o_start[n] <= wr_en && (blk == 4'(n)) && (reg_sel == 2'd0) && wword.cmd.start;
				o_stop[n]  <= wr_en && (blk == 4'(n)) && (reg_sel == 2'd0) && wword.cmd.stop;
				if (wr_en && (blk == 4'(n)) && (reg_sel == 2'd1)) begin
					o_speed_max[n] <= i_pwdata[`MOTOR_SPEED_W-1:0];
				end
			end
			if (wr_en && (i_paddr == RAMP_ADDR)) begin
				o_ramp_len <= i_pwdata[`MOTOR_ADDR_W-1:0];
			end
		end
	end

	// move parameters, sampled alongside the start strobe
	always_ff @(posedge clk) begin
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			if (wr_en && (blk == 4'(n)) && (reg_sel == 2'd0)) begin
				o_cmd_dir[n]   <= wword.cmd.dir;
				o_cmd_steps[n] <= wword.cmd.steps;
			end
		end
	end

	assign o_tbl_we   = wr_en && (i_paddr == TBL_ADDR);
	assign o_tbl_addr = wword.tbl.addr;
	assign o_tbl_data = wword.tbl.speed;

	always_comb begin
		o_prdata = '0;
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			if (blk == 4'(n)) begin
				case (reg_sel)
					2'd1: o_prdata = 32'(o_speed_max[n]);
					// busy covers prepare as well as running
					2'd2: o_prdata = {30'b0, i_dir[n], i_state[n] != motor_pkg::AXIS_IDLE};
					2'd3: o_prdata = 32'(i_position[n]);
					default: o_prdata = '0;
				endcase
			end
		end
		if (i_paddr == RAMP_ADDR) begin
			o_prdata = 32'(o_ramp_len);
		end
	end

endmodule

/* logic/profile_ram.sv */
`timescale 1ns/1ns
`include "motor_cfg.svh"

module profile_ram (
	input  logic                      clk,
	input  logic                      i_we,
	input  logic [`MOTOR_ADDR_W-1:0]  i_waddr,
	input  logic [`MOTOR_SPEED_W-1:0] i_wdata,
	input  logic [`MOTOR_ADDR_W-1:0]  i_raddr,
	output logic [`MOTOR_SPEED_W-1:0] o_rdata
);
	logic [`MOTOR_SPEED_W-1:0] mem [`MOTOR_TBL_DEPTH];

	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// data one cycle after the granted address
	always_ff @(posedge clk) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

/* logic/profile_arbiter.sv */
`timescale 1ns/1ns
`include "motor_cfg.svh"

module profile_arbiter (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic [`MOTOR_AXES-1:0]   i_req,
	input  logic [`MOTOR_ADDR_W-1:0] i_addr [`MOTOR_AXES],
	output logic [`MOTOR_AXES-1:0]   o_grant,
	output logic [`MOTOR_ADDR_W-1:0] o_raddr,
	output logic [`MOTOR_AXES-1:0]   o_rvalid
);
	localparam int PTR_W = (`MOTOR_AXES > 1) ? $clog2(`MOTOR_AXES) : 1;

	logic [PTR_W-1:0] prio;
	logic [PTR_W-1:0] gnt_idx;
	logic             gnt_any;

	// first requester at or after the priority pointer
	always_comb begin
		int idx;
		o_grant = '0;
		gnt_idx = '0;
		gnt_any = 1'b0;
		for (int k = 0; k < `MOTOR_AXES; k++) begin
			idx = (int'(prio) + k) % `MOTOR_AXES;
			if (!gnt_any && i_req[idx]) begin
				gnt_any      = 1'b1;
				gnt_idx      = PTR_W'(idx);
				o_grant[idx] = 1'b1;
			end
		end
	end

	assign o_raddr = i_addr[gnt_idx];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			prio     <= '0;
			o_rvalid <= '0;
		end else begin
			o_rvalid <= o_grant;
			// winner drops to lowest priority
			if (gnt_any) begin
				prio <= (int'(gnt_idx) == `MOTOR_AXES - 1) ? '0 : gnt_idx + 1'b1;
			end
		end
	end

endmodule

/* logic/step_axis.sv */
`timescale 1ns/1ns
`include "motor_cfg.svh"

module step_axis (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic                            i_start,
	input  logic                            i_stop,
	input  logic                            i_dir,
	input  logic [`MOTOR_STEP_W-1:0]        i_steps,
	input  logic [`MOTOR_SPEED_W-1:0]       i_speed_max,
	input  logic [`MOTOR_ADDR_W-1:0]        i_ramp_len,
	input  logic                            i_grant,
	input  logic                            i_rvalid,
	input  logic [`MOTOR_SPEED_W-1:0]       i_rdata,
	output logic                            o_req,
	output logic [`MOTOR_ADDR_W-1:0]        o_addr,
	output motor_pkg::axis_state_e          o_state,
	output logic                            o_drive,
	output logic                            o_dir,
	output logic signed [`MOTOR_STEP_W-1:0] o_position
);
	localparam int DLY_W = $clog2(`MOTOR_REVERSE_DELAY + 1);

	logic [`MOTOR_STEP_W-1:0]  steps_done;
	logic [`MOTOR_STEP_W-1:0]  steps_left;
	logic                      last_step;
	logic [DLY_W-1:0]          delay_cnt;
	logic [`MOTOR_SPEED_W-1:0] half_cnt;
	logic [`MOTOR_SPEED_W-1:0] speed_cur;
	logic                      spd_valid;
	logic                      fetch_go;
	logic                      f_busy;
	logic                      f_dec;
	logic [`MOTOR_SPEED_W-1:0] acc_val;
	logic [`MOTOR_ADDR_W-1:0]  acc_addr;
	logic [`MOTOR_ADDR_W-1:0]  dec_addr;
	logic [`MOTOR_SPEED_W-1:0] ramp_val;
	logic [`MOTOR_SPEED_W-1:0] spd_pick;
	logic                      do_start;
	logic                      do_stop;
	logic                      rise;
	logic                      fall;

	assign do_start = (o_state == motor_pkg::AXIS_IDLE) && i_start && (i_steps != '0);
	assign do_stop  = (o_state != motor_pkg::AXIS_IDLE) && i_stop;

	// prepare exit doubles as the first rising edge
	assign rise = ((o_state == motor_pkg::AXIS_PREPARE) && spd_valid && (delay_cnt == '0))
		|| ((o_state == motor_pkg::AXIS_RUNNING) && (half_cnt == '0) && !o_drive);
	assign fall = (o_state == motor_pkg::AXIS_RUNNING) && (half_cnt == '0) && o_drive;

	// table addresses saturate at the ramp end
	assign acc_addr = (steps_done < `MOTOR_STEP_W'(i_ramp_len)) ?
		steps_done[`MOTOR_ADDR_W-1:0] : i_ramp_len;
	assign dec_addr = (steps_left < `MOTOR_STEP_W'(i_ramp_len)) ?
		steps_left[`MOTOR_ADDR_W-1:0] : i_ramp_len;

	// slowest of accel, decel and limit
	assign ramp_val = (acc_val > i_rdata) ? acc_val : i_rdata;
	assign spd_pick = (ramp_val > i_speed_max) ? ramp_val : i_speed_max;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_state    <= motor_pkg::AXIS_IDLE;
			o_drive    <= 1'b0;
			o_dir      <= 1'b0;
			o_position <= '0;
			half_cnt   <= '0;
			delay_cnt  <= '0;
			last_step  <= 1'b0;
			fetch_go   <= 1'b0;
		end else begin
			fetch_go <= 1'b0;
			if (do_stop) begin
				o_state <= motor_pkg::AXIS_IDLE;
				o_drive <= 1'b0;
			end else if (do_start) begin
				o_state   <= motor_pkg::AXIS_PREPARE;
				o_dir     <= i_dir;
				delay_cnt <= (i_dir != o_dir) ? DLY_W'(`MOTOR_REVERSE_DELAY) : '0;
				last_step <= 1'b0;
				fetch_go  <= 1'b1;
			end else if (rise) begin
				o_state    <= motor_pkg::AXIS_RUNNING;
				o_drive    <= 1'b1;
				half_cnt   <= speed_cur;
				o_position <= o_dir ? o_position - 1'b1 : o_position + 1'b1;
				// no fetch needed after the final step
				if (steps_left == '0) begin
					last_step <= 1'b1;
				end else begin
					fetch_go <= 1'b1;
				end
			end else if (fall) begin
				o_drive  <= 1'b0;
				half_cnt <= speed_cur;
				if (last_step) begin
					o_state <= motor_pkg::AXIS_IDLE;
				end
			end else begin
				if ((o_state == motor_pkg::AXIS_PREPARE) && (delay_cnt != '0)) begin
					delay_cnt <= delay_cnt - 1'b1;
				end
				if (o_state == motor_pkg::AXIS_RUNNING) begin
					half_cnt <= half_cnt - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_start) begin
			steps_done <= '0;
			steps_left <= i_steps - 1'b1;
		end else if (rise) begin
			steps_done <= steps_done + 1'b1;
			if (steps_left != '0) begin
				steps_left <= steps_left - 1'b1;
			end
		end
	end

	// two reads per step, accel entry first
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_req     <= 1'b0;
			f_busy    <= 1'b0;
			f_dec     <= 1'b0;
			spd_valid <= 1'b0;
		end else if (do_stop) begin
			o_req  <= 1'b0;
			f_busy <= 1'b0;
		end else begin
			if (do_start) begin
				spd_valid <= 1'b0;
			end
			if (fetch_go) begin
				o_req  <= 1'b1;
				f_busy <= 1'b1;
				f_dec  <= 1'b0;
			end else if (o_req && i_grant) begin
				o_req <= 1'b0;
			end else if (f_busy && i_rvalid) begin
				if (!f_dec) begin
					o_req <= 1'b1;
					f_dec <= 1'b1;
				end else begin
					f_busy    <= 1'b0;
					spd_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_go) begin
			o_addr <= acc_addr;
		end else if (f_busy && i_rvalid && !f_dec) begin
			o_addr  <= dec_addr;
			acc_val <= i_rdata;
		end
		if (f_busy && i_rvalid && f_dec) begin
			speed_cur <= spd_pick;
		end
	end

endmodule

/* logic/motor_top.sv */
`timescale 1ns/1ns
`include "motor_cfg.svh"

module motor_top (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [7:0]             i_paddr,
	input  logic [31:0]            i_pwdata,
	output logic [31:0]            o_prdata,
	output logic [`MOTOR_AXES-1:0] o_drive,
	output logic [`MOTOR_AXES-1:0] o_dir
);
	logic [`MOTOR_AXES-1:0]          start;
	logic [`MOTOR_AXES-1:0]          stop;
	logic [`MOTOR_AXES-1:0]          cmd_dir;
	logic [`MOTOR_STEP_W-1:0]        cmd_steps [`MOTOR_AXES];
	logic [`MOTOR_SPEED_W-1:0]       speed_max [`MOTOR_AXES];
	logic [`MOTOR_ADDR_W-1:0]        ramp_len;
	logic                            tbl_we;
	logic [`MOTOR_ADDR_W-1:0]        tbl_addr;
	logic [`MOTOR_SPEED_W-1:0]       tbl_data;
	motor_pkg::axis_state_e          axis_state [`MOTOR_AXES];
	logic signed [`MOTOR_STEP_W-1:0] position [`MOTOR_AXES];
	logic [`MOTOR_AXES-1:0]          req;
	logic [`MOTOR_ADDR_W-1:0]        req_addr [`MOTOR_AXES];
	logic [`MOTOR_AXES-1:0]          grant;
	logic [`MOTOR_AXES-1:0]          rvalid;
	logic [`MOTOR_ADDR_W-1:0]        raddr;
	logic [`MOTOR_SPEED_W-1:0]       rdata;

	apb_regs i_apb_regs (
		.clk         (clk),
		.resetn      (resetn),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.i_state     (axis_state),
		.i_dir       (o_dir),
		.i_position  (position),
		.o_prdata    (o_prdata),
		.o_start     (start),
		.o_stop      (stop),
		.o_cmd_dir   (cmd_dir),
		.o_cmd_steps (cmd_steps),
		.o_speed_max (speed_max),
		.o_ramp_len  (ramp_len),
		.o_tbl_we    (tbl_we),
		.o_tbl_addr  (tbl_addr),
		.o_tbl_data  (tbl_data)
	);

	for (genvar n = 0; n < `MOTOR_AXES; n++) begin : g_axis
		step_axis i_step_axis (
			.clk         (clk),
			.resetn      (resetn),
			.i_start     (start[n]),
			.i_stop      (stop[n]),
			.i_dir       (cmd_dir[n]),
			.i_steps     (cmd_steps[n]),
			.i_speed_max (speed_max[n]),
			.i_ramp_len  (ramp_len),
			.i_grant     (grant[n]),
			.i_rvalid    (rvalid[n]),
			.i_rdata     (rdata),
			.o_req       (req[n]),
			.o_addr      (req_addr[n]),
			.o_state     (axis_state[n]),
			.o_drive     (o_drive[n]),
			.o_dir       (o_dir[n]),
			.o_position  (position[n])
		);
	end

	profile_arbiter i_profile_arbiter (
		.clk      (clk),
		.resetn   (resetn),
		.i_req    (req),
		.i_addr   (req_addr),
		.o_grant  (grant),
		.o_raddr  (raddr),
		.o_rvalid (rvalid)
	);

	profile_ram i_profile_ram (
		.clk     (clk),
		.i_we    (tbl_we),
		.i_waddr (tbl_addr),
		.i_wdata (tbl_data),
		.i_raddr (raddr),
		.o_rdata (rdata)
	);

endmodule

/* tb/motor_checker.sv */
`timescale 1ns/1ns
`include "motor_cfg.svh"

module motor_checker #(
	parameter int RAMP_LEN = 8
) (
	input  logic                            clk,
	input  logic [`MOTOR_AXES-1:0]          i_drive,
	input  logic [`MOTOR_AXES-1:0]          i_dir,
	input  logic                            i_arm,
	input  logic                            i_done,
	input  logic                            i_final,
	input  logic [`MOTOR_AXES-1:0]          i_mask,
	input  logic                            i_cmd_dir,
	input  int                              i_steps,
	input  int                              i_limit,
	input  int                              i_exp_pulses,
	input  int                              i_exp_pos [`MOTOR_AXES],
	input  logic                            i_stop_sent,
	input  logic [`MOTOR_AXES-1:0]          i_busy,
	input  logic signed [`MOTOR_STEP_W-1:0] i_pos [`MOTOR_AXES],
	output int                              o_errors
);
	int   pulses [`MOTOR_AXES];
	int   high_len [`MOTOR_AXES];
	logic prev_drive [`MOTOR_AXES];
	int   test_no;
	int   test_errs;
	int   passed;
	int   failed;

	initial begin
		o_errors = 0;
		test_no = 0;
		test_errs = 0;
		passed = 0;
		failed = 0;
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			pulses[n] = 0;
			high_len[n] = 0;
			prev_drive[n] = 1'b0;
		end
	end

	// speed table contents as loaded by the testbench
	function automatic int ramp_entry(input int k);
		if (k < 8) begin
			return 200 - 20 * k;
		end
		return 60;
	endfunction

	// slowest of accel entry, decel entry and the limit
	function automatic int expected_half(input int k, input int n, input int lim);
		int a;
		int d;
		int h;
		a = (k < RAMP_LEN) ? k : RAMP_LEN;
		d = (n - 1 - k < RAMP_LEN) ? n - 1 - k : RAMP_LEN;
		h = ramp_entry(a);
		if (ramp_entry(d) > h) begin
			h = ramp_entry(d);
		end
		if (lim > h) begin
			h = lim;
		end
		return h;
	endfunction

	task automatic flag_error(input string msg);
		$display("%s", msg);
		test_errs++;
		o_errors++;
	endtask

	task automatic check_phase(input int n);
		int exp_len;
		exp_len = expected_half(pulses[n] - 1, i_steps, i_limit) + 1;
		// a phase cut short by a stop has no fixed width
		if (i_mask[n] && !i_stop_sent && high_len[n] != exp_len) begin
			flag_error($sformatf("ERROR o_drive[%0d] high phase %0d: got 0x%0h expected 0x%0h",
				n, pulses[n] - 1, high_len[n], exp_len));
		end
	endtask

	task automatic finish_test();
		int exp_cnt;
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			exp_cnt = i_mask[n] ? i_exp_pulses : 0;
			if (pulses[n] != exp_cnt) begin
				flag_error($sformatf("ERROR o_drive[%0d] pulse count: got 0x%0h expected 0x%0h",
					n, pulses[n], exp_cnt));
			end
			if (i_mask[n] && i_dir[n] != i_cmd_dir) begin
				flag_error($sformatf("ERROR o_dir[%0d]: got 0x%0h expected 0x%0h",
					n, i_dir[n], i_cmd_dir));
			end
			if (i_drive[n]) begin
				flag_error($sformatf("ERROR o_drive[%0d] after move: got 0x1 expected 0x0", n));
			end
			if (i_busy[n]) begin
				flag_error($sformatf("ERROR STATUS[%0d] running: got 0x1 expected 0x0", n));
			end
			if (i_pos[n] != 16'(i_exp_pos[n])) begin
				flag_error($sformatf("ERROR POSITION[%0d]: got 0x%0h expected 0x%0h",
					n, i_pos[n], 16'(i_exp_pos[n])));
			end
		end
		test_no++;
		if (test_errs == 0) begin
			passed++;
			$display("test %0d: ok", test_no);
		end else begin
			failed++;
			$display("test %0d: %0d errors", test_no, test_errs);
		end
	endtask

	always @(negedge clk) begin
		if (i_arm) begin
			test_errs = 0;
			for (int n = 0; n < `MOTOR_AXES; n++) begin
				pulses[n] = 0;
				high_len[n] = 0;
			end
		end
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			if (i_drive[n] && !prev_drive[n]) begin
				pulses[n]++;
			end
			if (i_drive[n]) begin
				high_len[n]++;
			end else if (prev_drive[n]) begin
				check_phase(n);
				high_len[n] = 0;
			end
			prev_drive[n] = i_drive[n];
		end
		if (i_done) begin
			finish_test();
		end
		if (i_final) begin
			$display("tests %0d, passed %0d, failed %0d, errors %0d",
				test_no, passed, failed, o_errors);
		end
	end

endmodule

/* tb/tb_motor.sv */
`timescale 1ns/1ns
`include "motor_cfg.svh"

module tb_motor;
	localparam int RAMP_LEN = 8;
	localparam int NUM_ROWS = 7;

	typedef struct packed {
		logic [`MOTOR_AXES-1:0] mask;
		logic                   dir;
		int                     steps;
		int                     limit;
		int                     stop_at;
		int                     exp_pulses;
		int                     exp_pos0;
		int                     exp_pos1;
	} row_t;

	logic                            clk;
	logic                            resetn;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [7:0]                      paddr;
	logic [31:0]                     pwdata;
	logic [31:0]                     prdata;
	logic [`MOTOR_AXES-1:0]          drive;
	logic [`MOTOR_AXES-1:0]          dir;
	logic                            arm;
	logic                            done;
	logic                            final_report;
	logic                            stop_sent;
	logic [`MOTOR_AXES-1:0]          chk_mask;
	logic                            chk_dir;
	int                              chk_steps;
	int                              chk_limit;
	int                              chk_pulses;
	int                              chk_exp_pos [`MOTOR_AXES];
	logic [`MOTOR_AXES-1:0]          busy;
	logic signed [`MOTOR_STEP_W-1:0] chk_pos [`MOTOR_AXES];
	int                              errors;
	int                              wd_cycles;
	row_t                            rows [NUM_ROWS];

	motor_top i_motor_top (
		.clk       (clk),
		.resetn    (resetn),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_drive   (drive),
		.o_dir     (dir)
	);

	motor_checker #(.RAMP_LEN(RAMP_LEN)) i_motor_checker (
		.clk          (clk),
		.i_drive      (drive),
		.i_dir        (dir),
		.i_arm        (arm),
		.i_done       (done),
		.i_final      (final_report),
		.i_mask       (chk_mask),
		.i_cmd_dir    (chk_dir),
		.i_steps      (chk_steps),
		.i_limit      (chk_limit),
		.i_exp_pulses (chk_pulses),
		.i_exp_pos    (chk_exp_pos),
		.i_stop_sent  (stop_sent),
		.i_busy       (busy),
		.i_pos        (chk_pos),
		.o_errors     (errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		data = prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	function automatic logic [31:0] cmd_word(input logic start, input logic stop,
		input logic d, input int steps);
		motor_pkg::apb_wword_u w;
		w = '0;
		w.cmd.start = start;
		w.cmd.stop = stop;
		w.cmd.dir = d;
		w.cmd.steps = steps[`MOTOR_STEP_W-1:0];
		return w;
	endfunction

	task automatic load_table();
		motor_pkg::apb_wword_u w;
		int value;
		for (int k = 0; k < `MOTOR_TBL_DEPTH; k++) begin
			value = (k < 8) ? 200 - 20 * k : 60;
			w = '0;
			w.tbl.addr = k[`MOTOR_ADDR_W-1:0];
			w.tbl.speed = value[`MOTOR_SPEED_W-1:0];
			apb_write(8'h40, w);
		end
		apb_write(8'h44, 32'(RAMP_LEN));
	endtask

	task automatic run_row(input row_t r);
		logic [31:0]            rd;
		logic [`MOTOR_AXES-1:0] running;
		chk_mask = r.mask;
		chk_dir = r.dir;
		chk_steps = r.steps;
		chk_limit = r.limit;
		chk_pulses = r.exp_pulses;
		chk_exp_pos[0] = r.exp_pos0;
		chk_exp_pos[1] = r.exp_pos1;
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			if (r.mask[n]) begin
				apb_write(8'(n * 16 + 4), 32'(r.limit));
			end
		end
		arm = 1'b1;
		@(posedge clk);
		#1;
		arm = 1'b0;
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			if (r.mask[n]) begin
				apb_write(8'(n * 16), cmd_word(1'b1, 1'b0, r.dir, r.steps));
			end
		end
		if (r.stop_at != 0) begin
			repeat (r.stop_at) @(posedge clk);
			#1;
			stop_sent = 1'b1;
			for (int n = 0; n < `MOTOR_AXES; n++) begin
				if (r.mask[n]) begin
					apb_write(8'(n * 16), cmd_word(1'b0, 1'b1, r.dir, r.steps));
				end
			end
		end
		// poll STATUS until every axis of the row is idle
		do begin
			running = '0;
			for (int n = 0; n < `MOTOR_AXES; n++) begin
				if (r.mask[n]) begin
					apb_read(8'(n * 16 + 8), rd);
					running[n] = rd[0];
				end
			end
		end while (running != '0);
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			apb_read(8'(n * 16 + 12), rd);
			chk_pos[n] = rd[`MOTOR_STEP_W-1:0];
			apb_read(8'(n * 16 + 8), rd);
			busy[n] = rd[0];
		end
		done = 1'b1;
		@(posedge clk);
		#1;
		done = 1'b0;
		stop_sent = 1'b0;
	endtask

	initial begin
		resetn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		arm = 1'b0;
		done = 1'b0;
		final_report = 1'b0;
		stop_sent = 1'b0;
		chk_mask = '0;
		chk_dir = 1'b0;
		chk_steps = 0;
		chk_limit = 0;
		chk_pulses = 0;
		busy = '0;
		for (int n = 0; n < `MOTOR_AXES; n++) begin
			chk_exp_pos[n] = 0;
			chk_pos[n] = '0;
		end
		// mask, dir, steps, limit, stop cycle, pulses, position 0, position 1
		rows[0] = '{2'b01, 1'b0, 20, 0, 0, 20, 20, 0};
		rows[1] = '{2'b01, 1'b1, 5, 0, 0, 5, 15, 0};
		rows[2] = '{2'b01, 1'b1, 12, 100, 0, 12, 3, 0};
		rows[3] = '{2'b10, 1'b0, 1, 0, 0, 1, 3, 1};
		// stop lands in the high phase of the third step
		rows[4] = '{2'b10, 1'b1, 20, 0, 800, 3, 3, -2};
		rows[5] = '{2'b11, 1'b0, 16, 0, 0, 16, 19, 14};
		rows[6] = '{2'b11, 1'b0, 10, 120, 0, 10, 29, 24};
		wd_cycles = 4 * `MOTOR_TBL_DEPTH + 2000;
		for (int t = 0; t < NUM_ROWS; t++) begin
			wd_cycles += rows[t].steps * 2 * 201;
		end
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		load_table();
		for (int t = 0; t < NUM_ROWS; t++) begin
			run_row(rows[t]);
		end
		final_report = 1'b1;
		@(posedge clk);
		#1;
		final_report = 1'b0;
		@(posedge clk);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: the moves did not finish within %0d clock cycles", wd_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+logic
logic/motor_pkg.sv
logic/apb_regs.sv
logic/profile_ram.sv
logic/profile_arbiter.sv
logic/step_axis.sv
logic/motor_top.sv
tb/motor_checker.sv
tb/tb_motor.sv

/* run.sh */
#!/bin/sh
verilator --binary -j 0 --top-module tb_motor -f list.f -o tb_motor_sim &&
	./obj_dir/tb_motor_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
	echo "simulation passed" || { echo "simulation failed"; exit 1; }
